//--- src/vmu_cfg_pkg.sv
// Vector memory unit sizing
// Lane count, element and address widths, register count and order depth

package vmu_cfg_pkg;

    // ====================
    // Vector shape
    // ====================
    localparam int VECTOR_LANES = 4;
    localparam int DATA_WIDTH   = 32;
    localparam int ADDR_WIDTH   = 32;
    localparam int ELEM_BYTES   = 4;

    // Register file
    localparam int VREG_COUNT = 8;

    // Order buffer
    localparam int ORDER_DEPTH = 3;

    // ====================
    // Derived index widths
    // ====================
    localparam int LANE_BITS      = $clog2(VECTOR_LANES);
    localparam int VREG_BITS      = $clog2(VREG_COUNT);
    localparam int ORDER_PTR_BITS = $clog2(ORDER_DEPTH);
    localparam int ORDER_CNT_BITS = $clog2(ORDER_DEPTH + 1);

endpackage

//--- src/vmu_types_pkg.sv
// Vector memory unit types
// Payloads and tags carried between the dispatcher, engines and arbiter

package vmu_types_pkg;

    // Owner of an order buffer entry
    typedef enum logic {
        TAG_LOAD  = 1'b0,
        TAG_STORE = 1'b1
    } engine_tag_t;

    // Vector register number
    typedef logic [vmu_cfg_pkg::VREG_BITS-1:0] vreg_addr_t;

    // Element index, doubles as request ticket
    typedef logic [vmu_cfg_pkg::LANE_BITS-1:0] lane_idx_t;

    // One element and one full vector
    typedef logic [vmu_cfg_pkg::DATA_WIDTH-1:0] elem_t;
    typedef elem_t [vmu_cfg_pkg::VECTOR_LANES-1:0] vec_t;

    // Byte address
    typedef logic [vmu_cfg_pkg::ADDR_WIDTH-1:0] addr_t;

endpackage

//--- src/vmu_order_if.sv
// Order buffer link
// Dispatcher pushes engine tags, arbiter reads the head and pops it

`timescale 1ns/1ns

interface vmu_order_if;

    logic                       push;
    vmu_types_pkg::engine_tag_t push_tag;
    logic                       space;
    logic                       pop;
    logic                       head_valid;
    vmu_types_pkg::engine_tag_t head_tag;

    modport producer (output push, output push_tag, input space);

    modport buffer (input push, input push_tag, input pop,
                    output space, output head_valid, output head_tag);

    modport consumer (output pop, input head_valid, input head_tag);

endinterface

//--- src/vmu_mem_req_if.sv
// Engine request link
// Start and busy toward the dispatcher, request and grant toward the arbiter

`timescale 1ns/1ns

interface vmu_mem_req_if;

    // Control
    logic start;
    logic busy;
    logic req;
    logic grant;

    // Request payload, stable while req waits for grant
    vmu_types_pkg::addr_t     addr;
    logic                     write;
    vmu_types_pkg::elem_t     data;
    vmu_types_pkg::lane_idx_t ticket;

    modport dispatch (output start, input busy);

    modport engine (input start, input grant,
                    output busy, output req, output addr, output write,
                    output data, output ticket);

    modport arbiter (input busy, input req, input addr, input write,
                     input data, input ticket, output grant);

endinterface

//--- src/vmu_dispatch.sv
// Instruction dispatcher
// Accepts one instruction at a time, starts the target engine
// and records its tag in the order buffer

`timescale 1ns/1ns

module vmu_dispatch (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  instr_valid_i,
    input  logic  instr_is_store_i,
    output logic  instr_ready_o,
    output logic  idle_o,
    vmu_order_if.producer   ord,
    vmu_mem_req_if.dispatch ld,
    vmu_mem_req_if.dispatch st
);

    logic target_free;
    logic accept;

    // Target engine idle and room for one more entry
    assign target_free   = instr_is_store_i ? ~st.busy : ~ld.busy;
    assign instr_ready_o = target_free & ord.space;
    assign accept        = instr_valid_i & instr_ready_o;

    // Start strobes
    assign ld.start = accept & ~instr_is_store_i;
    assign st.start = accept & instr_is_store_i;

    // Age order entry
    assign ord.push     = accept;
    assign ord.push_tag = instr_is_store_i ? vmu_types_pkg::TAG_STORE
                                           : vmu_types_pkg::TAG_LOAD;

    // Idle once both engines are done and nothing new came in
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idle_o <= 1'b1;
        end else begin
            idle_o <= ~ld.busy & ~st.busy & ~accept;
        end
    end

endmodule

//--- src/vmu_order_fifo.sv
// Order buffer
// Circular buffer of engine tags, oldest instruction at the head

`timescale 1ns/1ns

module vmu_order_fifo (
    input  logic clk,
    input  logic rst_n,
    vmu_order_if.buffer ord
);

    localparam logic [vmu_cfg_pkg::ORDER_PTR_BITS-1:0] LAST_PTR =
        vmu_cfg_pkg::ORDER_PTR_BITS'(vmu_cfg_pkg::ORDER_DEPTH - 1);
    localparam logic [vmu_cfg_pkg::ORDER_CNT_BITS-1:0] FULL_CNT =
        vmu_cfg_pkg::ORDER_CNT_BITS'(vmu_cfg_pkg::ORDER_DEPTH);

    vmu_types_pkg::engine_tag_t tag_mem [vmu_cfg_pkg::ORDER_DEPTH];

    logic [vmu_cfg_pkg::ORDER_PTR_BITS-1:0] wr_ptr;
    logic [vmu_cfg_pkg::ORDER_PTR_BITS-1:0] rd_ptr;
    logic [vmu_cfg_pkg::ORDER_CNT_BITS-1:0] count;

    assign ord.space      = (count != FULL_CNT);
    assign ord.head_valid = (count != '0);
    assign ord.head_tag   = tag_mem[rd_ptr];

    // Pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (ord.push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (ord.pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            if (ord.push && !ord.pop) begin
                count <= count + 1'b1;
            end else if (!ord.push && ord.pop) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ord.push) begin
            tag_mem[wr_ptr] <= ord.push_tag;
        end
    end

endmodule

//--- src/vmu_mem_arbiter.sv
// Memory port arbiter
// Only the engine that owns the oldest order entry reaches the cache,
// so requests of two instructions never interleave

`timescale 1ns/1ns

module vmu_mem_arbiter (
    vmu_order_if.consumer  ord,
    vmu_mem_req_if.arbiter ld,
    vmu_mem_req_if.arbiter st,
    input  logic                     mem_ready_i,
    output logic                     mem_req_valid_o,
    output logic                     mem_req_write_o,
    output vmu_types_pkg::addr_t     mem_req_addr_o,
    output vmu_types_pkg::elem_t     mem_req_data_o,
    output vmu_types_pkg::lane_idx_t mem_req_ticket_o
);

    logic head_is_ld;
    logic head_is_st;
    logic owner_busy;

    assign head_is_ld = ord.head_valid & (ord.head_tag == vmu_types_pkg::TAG_LOAD);
    assign head_is_st = ord.head_valid & (ord.head_tag == vmu_types_pkg::TAG_STORE);

    // ====================
    // Grants
    // ====================
    assign ld.grant = head_is_ld & mem_ready_i & ld.req;
    assign st.grant = head_is_st & mem_ready_i & st.req;

    assign mem_req_valid_o = ld.grant | st.grant;

    // Payload of the head owner
    assign mem_req_write_o  = head_is_st ? st.write  : ld.write;
    assign mem_req_addr_o   = head_is_st ? st.addr   : ld.addr;
    assign mem_req_data_o   = head_is_st ? st.data   : ld.data;
    assign mem_req_ticket_o = head_is_st ? st.ticket : ld.ticket;

    // ====================
    // Retire head entry
    // ====================
    // Owner has finished all its transfers once busy drops
    assign owner_busy = head_is_st ? st.busy : ld.busy;
    assign ord.pop    = ord.head_valid & ~owner_busy;

endmodule

//--- src/vmu_load_engine.sv
// Vector load engine
// Issues one strided read per lane, gathers responses by ticket
// and writes the complete vector back to the register file

`timescale 1ns/1ns

module vmu_load_engine (
    input  logic                      clk,
    input  logic                      rst_n,
    input  vmu_types_pkg::vreg_addr_t instr_vreg_i,
    input  vmu_types_pkg::addr_t      instr_base_i,
    input  vmu_types_pkg::addr_t      instr_stride_i,
    vmu_mem_req_if.engine             req,
    input  logic                      mem_resp_valid_i,
    input  vmu_types_pkg::lane_idx_t  mem_resp_ticket_i,
    input  vmu_types_pkg::elem_t      mem_resp_data_i,
    output logic                      wb_en_o,
    output vmu_types_pkg::vreg_addr_t wb_reg_o,
    output vmu_types_pkg::vec_t       wb_data_o
);

    localparam vmu_types_pkg::lane_idx_t LAST_LANE =
        vmu_cfg_pkg::LANE_BITS'(vmu_cfg_pkg::VECTOR_LANES - 1);

    logic                                  busy_q;
    logic                                  issuing_q;
    vmu_types_pkg::lane_idx_t              issue_cnt_q;
    logic [vmu_cfg_pkg::VECTOR_LANES-1:0]  rcvd_q;
    logic [vmu_cfg_pkg::VECTOR_LANES-1:0]  rcvd_next;
    logic                                  all_rcvd;
    vmu_types_pkg::addr_t                  addr_q;
    vmu_types_pkg::addr_t                  stride_q;
    vmu_types_pkg::vreg_addr_t             vreg_q;
    vmu_types_pkg::vec_t                   lane_buf_q;

    // Request side
    assign req.busy   = busy_q;
    assign req.req    = issuing_q;
    assign req.addr   = addr_q;
    assign req.write  = 1'b0;
    assign req.data   = '0;
    assign req.ticket = issue_cnt_q;

    // Mask after the current response lands
    always_comb begin
        rcvd_next = rcvd_q;
        if (mem_resp_valid_i) begin
            rcvd_next[mem_resp_ticket_i] = 1'b1;
        end
    end
    assign all_rcvd = busy_q & mem_resp_valid_i & (&rcvd_next);

    // ====================
    // Control
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q      <= 1'b0;
            issuing_q   <= 1'b0;
            issue_cnt_q <= '0;
            rcvd_q      <= '0;
            wb_en_o     <= 1'b0;
        end else begin
            wb_en_o <= all_rcvd;
            if (req.start) begin
                busy_q      <= 1'b1;
                issuing_q   <= 1'b1;
                issue_cnt_q <= '0;
                rcvd_q      <= '0;
            end else begin
                if (req.grant) begin
                    issue_cnt_q <= issue_cnt_q + 1'b1;
                    if (issue_cnt_q == LAST_LANE) begin
                        issuing_q <= 1'b0;
                    end
                end
                if (busy_q) begin
                    rcvd_q <= rcvd_next;
                end
                // Busy drops together with the writeback pulse
                if (all_rcvd) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // Address walk and gathered data
    always_ff @(posedge clk) begin
        if (req.start) begin
            vreg_q   <= instr_vreg_i;
            addr_q   <= instr_base_i;
            stride_q <= vmu_cfg_pkg::ADDR_WIDTH'(instr_stride_i * vmu_cfg_pkg::ELEM_BYTES);
        end else if (req.grant) begin
            addr_q <= addr_q + stride_q;
        end
        if (mem_resp_valid_i) begin
            lane_buf_q[mem_resp_ticket_i] <= mem_resp_data_i;
        end
    end

    assign wb_reg_o  = vreg_q;
    assign wb_data_o = lane_buf_q;

endmodule

//--- src/vmu_store_engine.sv
// Vector store engine
// Reads one vector register and writes its lanes to a strided address run

`timescale 1ns/1ns

module vmu_store_engine (
    input  logic                      clk,
    input  logic                      rst_n,
    input  vmu_types_pkg::vreg_addr_t instr_vreg_i,
    input  vmu_types_pkg::addr_t      instr_base_i,
    input  vmu_types_pkg::addr_t      instr_stride_i,
    vmu_mem_req_if.engine             req,
    output vmu_types_pkg::vreg_addr_t rf_rd_addr_o,
    input  vmu_types_pkg::vec_t       rf_rd_data_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_SEND
    } st_state_t;

    localparam vmu_types_pkg::lane_idx_t LAST_LANE =
        vmu_cfg_pkg::LANE_BITS'(vmu_cfg_pkg::VECTOR_LANES - 1);

    st_state_t                 state_q;
    vmu_types_pkg::lane_idx_t  lane_q;
    vmu_types_pkg::addr_t      addr_q;
    vmu_types_pkg::addr_t      stride_q;
    vmu_types_pkg::vreg_addr_t vreg_q;
    vmu_types_pkg::vec_t       data_q;

    assign req.busy   = (state_q != ST_IDLE);
    assign req.req    = (state_q == ST_SEND);
    assign req.addr   = addr_q;
    assign req.write  = 1'b1;
    assign req.data   = data_q[lane_q];
    assign req.ticket = lane_q;

    // Register read goes out in ST_READ
    assign rf_rd_addr_o = vreg_q;

    // ====================
    // FSM and lane counter
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            lane_q  <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req.start) begin
                        state_q <= ST_READ;
                        lane_q  <= '0;
                    end
                end
                ST_READ: state_q <= ST_SEND;
                ST_SEND: begin
                    if (req.grant) begin
                        lane_q <= lane_q + 1'b1;
                        if (lane_q == LAST_LANE) begin
                            state_q <= ST_IDLE;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Instruction fields, captured vector and address walk
    always_ff @(posedge clk) begin
        if (req.start) begin
            vreg_q   <= instr_vreg_i;
            addr_q   <= instr_base_i;
            stride_q <= vmu_cfg_pkg::ADDR_WIDTH'(instr_stride_i * vmu_cfg_pkg::ELEM_BYTES);
        end else if (req.grant) begin
            addr_q <= addr_q + stride_q;
        end
        if (state_q == ST_READ) begin
            data_q <= rf_rd_data_i;
        end
    end

endmodule

//--- src/vmu_top.sv
// Vector memory unit top level
// Dispatcher, order buffer, memory arbiter and the load and store engines

`timescale 1ns/1ns

module vmu_top (
    input  logic                      clk,
    input  logic                      rst_n,
    // Instruction
    input  logic                      instr_valid_i,
    input  logic                      instr_is_store_i,
    input  vmu_types_pkg::vreg_addr_t instr_vreg_i,
    input  vmu_types_pkg::addr_t      instr_base_i,
    input  vmu_types_pkg::addr_t      instr_stride_i,
    output logic                      instr_ready_o,
    output logic                      idle_o,
    // Cache request and response
    output logic                      mem_req_valid_o,
    output logic                      mem_req_write_o,
    output vmu_types_pkg::addr_t      mem_req_addr_o,
    output vmu_types_pkg::elem_t      mem_req_data_o,
    output vmu_types_pkg::lane_idx_t  mem_req_ticket_o,
    input  logic                      mem_ready_i,
    input  logic                      mem_resp_valid_i,
    input  vmu_types_pkg::lane_idx_t  mem_resp_ticket_i,
    input  vmu_types_pkg::elem_t      mem_resp_data_i,
    // Register file
    output vmu_types_pkg::vreg_addr_t rf_rd_addr_o,
    input  vmu_types_pkg::vec_t       rf_rd_data_i,
    output logic                      wb_en_o,
    output vmu_types_pkg::vreg_addr_t wb_reg_o,
    output vmu_types_pkg::vec_t       wb_data_o
);

    vmu_order_if   ord_if ();
    vmu_mem_req_if ld_if ();
    vmu_mem_req_if st_if ();

    vmu_dispatch i_vmu_dispatch (
        .clk, .rst_n, .instr_valid_i, .instr_is_store_i, .instr_ready_o, .idle_o,
        .ord (ord_if), .ld (ld_if), .st (st_if)
    );

    vmu_order_fifo i_vmu_order_fifo (.clk, .rst_n, .ord (ord_if));

    vmu_mem_arbiter i_vmu_mem_arbiter (
        .ord (ord_if), .ld (ld_if), .st (st_if), .mem_ready_i, .mem_req_valid_o,
        .mem_req_write_o, .mem_req_addr_o, .mem_req_data_o, .mem_req_ticket_o
    );

    vmu_load_engine i_vmu_load_engine (
        .clk, .rst_n, .instr_vreg_i, .instr_base_i, .instr_stride_i, .req (ld_if),
        .mem_resp_valid_i, .mem_resp_ticket_i, .mem_resp_data_i,
        .wb_en_o, .wb_reg_o, .wb_data_o
    );

    vmu_store_engine i_vmu_store_engine (
        .clk, .rst_n, .instr_vreg_i, .instr_base_i, .instr_stride_i, .req (st_if),
        .rf_rd_addr_o, .rf_rd_data_i
    );

endmodule

//--- verification/vmu_tb.sv
// Vector memory unit testbench
// Register-file and memory models with reordered load responses
// LFSR strides and ready drops with checks on every transfer and writeback

`timescale 1ns/1ns

module vmu_tb;

    localparam int LANES = vmu_cfg_pkg::VECTOR_LANES;
    localparam int TEST_COUNT = 6;
    localparam int CYCLES_PER_TEST = 300;
    localparam int MARGIN = 2;
    localparam int IDLE_TIMEOUT = 400;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic instr_valid_i = 1'b0, instr_is_store_i = 1'b0;
    vmu_types_pkg::vreg_addr_t instr_vreg_i = '0;
    vmu_types_pkg::addr_t instr_base_i = '0, instr_stride_i = '0;
    logic instr_ready_o, idle_o, mem_req_valid_o, mem_req_write_o;
    vmu_types_pkg::addr_t mem_req_addr_o;
    vmu_types_pkg::elem_t mem_req_data_o;
    vmu_types_pkg::lane_idx_t mem_req_ticket_o;
    logic mem_ready_i = 1'b1, mem_resp_valid_i = 1'b0;
    vmu_types_pkg::lane_idx_t mem_resp_ticket_i = '0;
    vmu_types_pkg::elem_t mem_resp_data_i = '0;
    vmu_types_pkg::vreg_addr_t rf_rd_addr_o, wb_reg_o;
    vmu_types_pkg::vec_t rf_rd_data_i, wb_data_o;
    logic wb_en_o;

    // Models and bookkeeping
    vmu_types_pkg::vec_t rf [vmu_cfg_pkg::VREG_COUNT];
    vmu_types_pkg::elem_t mem [vmu_types_pkg::addr_t];
    logic [15:0] lfsr_q = 16'd30;
    logic drop_ready = 1'b0;
    string test_name = "reset";
    int errors = 0, tests_done = 0, err_mark = 0;
    logic q_store [$];
    vmu_types_pkg::vreg_addr_t q_vreg [$];
    vmu_types_pkg::addr_t q_base [$], q_stride [$];
    vmu_types_pkg::vreg_addr_t wb_exp_reg [$];
    vmu_types_pkg::vec_t wb_exp_data [$];
    vmu_types_pkg::vec_t load_vec;
    vmu_types_pkg::lane_idx_t resp_ticket [$];
    vmu_types_pkg::elem_t resp_data [$];
    int resp_wait [$];
    int req_cnt = 0, loads_open = 0;
    logic store_open = 1'b0;
    logic capture_pending = 1'b0;
    vmu_types_pkg::vreg_addr_t capture_vreg;
    vmu_types_pkg::vec_t st_vec [$];

    vmu_top i_vmu_top (.*);

    always #4 clk = ~clk;

    assign rf_rd_data_i = rf[rf_rd_addr_o];

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_bit());
        end
        return v;
    endfunction

    // Untouched memory reads a pattern of the full address
    function automatic vmu_types_pkg::elem_t mem_read(input vmu_types_pkg::addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    task automatic report_mismatch(input string what, input logic [127:0] exp_v,
                                   input logic [127:0] act_v);
        errors++;
        $display("ERROR %s: %s expected %0h actual %0h", test_name, what, exp_v, act_v);
    endtask

    // Never a request while the cache port is stalled
    a_valid_needs_ready: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid_o |-> mem_ready_i)
        else begin
            errors++;
            $display("ERROR %s: request valid while mem_ready_i low", test_name);
        end

    a_wb_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_en_o |=> !wb_en_o)
        else begin
            errors++;
            $display("ERROR %s: writeback strobe longer than one cycle", test_name);
        end

    // ====================
    // Monitor at falling edge
    // ====================
    always @(negedge clk) begin : monitor
        vmu_types_pkg::addr_t exp_addr;
        if (rst_n) begin
            if (wb_en_o) begin
                if (wb_exp_reg.size() == 0) begin
                    errors++;
                    $display("ERROR %s: writeback without a pending load", test_name);
                end else begin
                    assert (wb_reg_o == wb_exp_reg[0])
                        else report_mismatch("wb_reg", wb_exp_reg[0], wb_reg_o);
                    assert (wb_data_o == wb_exp_data[0])
                        else report_mismatch("wb_data", wb_exp_data[0], wb_data_o);
                    rf[wb_reg_o] = wb_data_o;
                    void'(wb_exp_reg.pop_front());
                    void'(wb_exp_data.pop_front());
                end
                loads_open--;
            end
            // Store engine reads its register one cycle after acceptance
            if (capture_pending) begin
                assert (rf_rd_addr_o == capture_vreg)
                    else report_mismatch("rf_rd_addr", capture_vreg, rf_rd_addr_o);
                st_vec.push_back(rf[capture_vreg]);
                capture_pending = 1'b0;
            end
            if (instr_valid_i && (instr_is_store_i ? store_open : loads_open > 0)) begin
                assert (!instr_ready_o)
                    else report_mismatch("instr_ready while engine busy", 0, instr_ready_o);
            end
            if (mem_req_valid_o && q_store.size() > 0) begin
                exp_addr = q_base[0] + vmu_types_pkg::addr_t'(req_cnt) * q_stride[0] * 4;
                assert (mem_req_write_o == q_store[0])
                    else report_mismatch("write", q_store[0], mem_req_write_o);
                assert (mem_req_addr_o == exp_addr)
                    else report_mismatch("addr", exp_addr, mem_req_addr_o);
                assert (mem_req_ticket_o == req_cnt[vmu_cfg_pkg::LANE_BITS-1:0])
                    else report_mismatch("ticket", req_cnt, mem_req_ticket_o);
                if (q_store[0]) begin
                    assert (mem_req_data_o == st_vec[0][req_cnt])
                        else report_mismatch("data", st_vec[0][req_cnt], mem_req_data_o);
                    mem[mem_req_addr_o] = mem_req_data_o;
                end else begin
                    load_vec[req_cnt] = mem_read(exp_addr);
                    resp_ticket.push_back(mem_req_ticket_o);
                    resp_data.push_back(mem_read(mem_req_addr_o));
                    resp_wait.push_back(1 + rand_bits(2));
                end
                req_cnt++;
                if (req_cnt == LANES) begin
                    if (q_store[0]) begin
                        store_open = 1'b0;
                        void'(st_vec.pop_front());
                    end else begin
                        wb_exp_reg.push_back(q_vreg[0]);
                        wb_exp_data.push_back(load_vec);
                    end
                    req_cnt = 0;
                    void'(q_store.pop_front());
                    void'(q_vreg.pop_front());
                    void'(q_base.pop_front());
                    void'(q_stride.pop_front());
                end
            end else if (mem_req_valid_o) begin
                errors++;
                $display("ERROR %s: request with no accepted instruction", test_name);
            end
            if (instr_valid_i && instr_ready_o) begin
                q_store.push_back(instr_is_store_i);
                q_vreg.push_back(instr_vreg_i);
                q_base.push_back(instr_base_i);
                q_stride.push_back(instr_stride_i);
                if (instr_is_store_i) begin
                    store_open = 1'b1;
                    capture_pending = 1'b1;
                    capture_vreg = instr_vreg_i;
                end else begin
                    loads_open++;
                end
            end
        end
    end

    // Out-of-order response release with one strobe per cycle
    always @(posedge clk) begin : responder
        int pick;
        pick = -1;
        mem_resp_valid_i <= 1'b0;
        for (int i = 0; i < resp_wait.size(); i++) begin
            if (resp_wait[i] > 0) begin
                resp_wait[i]--;
            end
            if (resp_wait[i] == 0 && pick < 0) begin
                pick = i;
            end
        end
        if (pick >= 0) begin
            mem_resp_valid_i  <= 1'b1;
            mem_resp_ticket_i <= resp_ticket[pick];
            mem_resp_data_i   <= resp_data[pick];
            resp_ticket.delete(pick);
            resp_data.delete(pick);
            resp_wait.delete(pick);
        end
    end

    always @(posedge clk) begin
        mem_ready_i <= drop_ready ? (rand_bits(2) != 0) : 1'b1;
    end

    task automatic issue(input logic is_store, input int vreg, input int base, input int stride);
        int waited;
        waited = 0;
        @(posedge clk);
        instr_valid_i    <= 1'b1;
        instr_is_store_i <= is_store;
        instr_vreg_i     <= vmu_types_pkg::vreg_addr_t'(vreg);
        instr_base_i     <= vmu_types_pkg::addr_t'(base);
        instr_stride_i   <= vmu_types_pkg::addr_t'(stride);
        @(negedge clk);
        while (!instr_ready_o && waited < IDLE_TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (!instr_ready_o) begin
            errors++;
            $display("Timed out waiting for instr_ready_o in test %s", test_name);
        end
        @(posedge clk);
        instr_valid_i <= 1'b0;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        repeat (3) @(negedge clk);
        while (!(idle_o && q_store.size() == 0 && wb_exp_reg.size() == 0)) begin
            waited++;
            if (waited > IDLE_TIMEOUT) begin
                errors++;
                $display("Timed out waiting for the unit to go idle in test %s", test_name);
                break;
            end
            @(negedge clk);
        end
        assert (instr_ready_o && resp_wait.size() == 0)
            else report_mismatch("ready and no responses left at idle", 1, instr_ready_o);
    endtask

    task automatic end_test();
        tests_done++;
        $display("test %-10s done, %0d errors", test_name, errors - err_mark);
        err_mark = errors;
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        for (int r = 0; r < vmu_cfg_pkg::VREG_COUNT; r++) begin
            for (int l = 0; l < LANES; l++) begin
                rf[r][l] = 32'hc0de_0000 + (r << 8) + l;
            end
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!mem_req_valid_o && !wb_en_o && idle_o && instr_ready_o)
            else report_mismatch("reset outputs", 4'b0011,
                                 {mem_req_valid_o, wb_en_o, idle_o, instr_ready_o});
        end_test();

        test_name = "store";
        issue(1'b1, 1, 'h100, 1 + rand_bits(2));
        wait_idle();
        end_test();

        test_name = "load";
        issue(1'b0, 5, 'h100, 1);
        issue(1'b0, 6, 'h800, 1 + rand_bits(2));
        wait_idle();
        end_test();

        test_name = "order";
        issue(1'b1, 2, 'h400, 2);
        issue(1'b0, 3, 'h400, 2);
        issue(1'b1, 3, 'h600, 1 + rand_bits(2));
        issue(1'b0, 4, 'h600, 0);
        wait_idle();
        end_test();

        test_name = "ready_drop";
        drop_ready = 1'b1;
        for (int k = 0; k < 4; k++) begin
            issue(1'b1, k, 'h1000 + k * 'h40, 1 + rand_bits(2));
            issue(1'b0, k + 4, 'h1000 + k * 'h40, 1 + rand_bits(2));
        end
        wait_idle();
        drop_ready = 1'b0;
        end_test();

        test_name = "busy";
        issue(1'b1, 7, 'h2000, 3);
        issue(1'b1, 0, 'h2100, 1);
        issue(1'b0, 1, 'h2000, 3);
        wait_idle();
        end_test();

        $display("tests %0d, errors %0d", tests_done, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(TEST_COUNT * CYCLES_PER_TEST * 8 * MARGIN);
        $display("Watchdog expired before the tests finished");
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- vmu_top.f
src/vmu_cfg_pkg.sv
src/vmu_types_pkg.sv
src/vmu_order_if.sv
src/vmu_mem_req_if.sv
src/vmu_dispatch.sv
src/vmu_order_fifo.sv
src/vmu_mem_arbiter.sv
src/vmu_load_engine.sv
src/vmu_store_engine.sv
src/vmu_top.sv
verification/vmu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the vector memory unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vmu_top.f --top-module vmu_tb \
    -Mdir obj_dir -o vmu_sim > build.log 2>&1 \
    && ./obj_dir/vmu_sim > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "^TB PASSED$" sim.log && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see sim.log"; exit 1; }
